/* hw/bridge_settings_regs.sv */
//////////////////////////////
// bridge settings registers
// deadzone and adapter settings word
// with write decode and readback mux
//////////////////////////////

`timescale 1ns/1ps

`include "pad_router_settings.svh"

module bridge_settings_regs (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,

  // bridge, synchronous to clk_74a
  input  pad_router_pkg::bridge_word_t  bridge_addr,
  input  logic                          bridge_wr,
  input  pad_router_pkg::bridge_word_t  bridge_wr_data,
  output pad_router_pkg::bridge_word_t  bridge_rd_data,

  // settings to the pipeline
  output pad_router_pkg::stick_axis_t   deadzone,
  output pad_router_pkg::cont_type_t    cont_type,
  output pad_router_pkg::assign_mode_t  assign_mode
);

  // stored adapter word
  pad_router_pkg::analogizer_cfg_t analogizer_settings;

  //////////////////////////////
  // write decode
  //////////////////////////////

  // exact address match, everything else is dropped
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      deadzone            <= '0;
      analogizer_settings <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        `PR_ADDR_DEADZONE: begin
          deadzone <= bridge_wr_data[7:0];
        end
        `PR_ADDR_ANALOGIZER: begin
          // upper bits of the data word are discarded
          analogizer_settings <= bridge_wr_data[`PR_SETTINGS_W-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////
  // readback
  //////////////////////////////

  // only the adapter word is readable
  always_comb begin
    bridge_rd_data = '0;
    if (bridge_addr == `PR_ADDR_ANALOGIZER) begin
      bridge_rd_data = pad_router_pkg::bridge_word_t'(analogizer_settings);
    end
  end

  //////////////////////////////
  // field split
  //////////////////////////////

  assign cont_type =
    analogizer_settings[`PR_CONT_TYPE_LSB +: `PR_CONT_TYPE_W];

  // codes past the last mode stay as they are and hit the default route
  assign assign_mode = pad_router_pkg::assign_mode_t'(
    analogizer_settings[`PR_ASSIGN_LSB +: `PR_ASSIGN_W]);

endmodule

/* hw/pad_router_pkg.sv */
//////////////////////////////
// shared data types for the pad router
// and the assignment mode encoding
//////////////////////////////

`include "pad_router_settings.svh"

package pad_router_pkg;

  // pocket key bitmap
  // [3:0] dpad up/down/left/right
  // [7:4] face a/b/x/y
  // [13:8] triggers l1 r1 l2 r2 l3 r3
  // [15:14] start and select
  typedef logic [15:0] pad_keys_t;

  // one unsigned stick axis, centre at 128
  typedef logic [7:0] stick_axis_t;

  // bridge address and data
  typedef logic [31:0] bridge_word_t;

  // adapter settings word as written over the bridge
  typedef logic [`PR_SETTINGS_W-1:0] analogizer_cfg_t;

  // adapter controller type
  typedef logic [`PR_CONT_TYPE_W-1:0] cont_type_t;

  // which player slots the adapter pads take over
  // codes 7 to 15 fall back to pocket controllers
  typedef enum logic [`PR_ASSIGN_W-1:0] {
    assign_p1_snac      = 0,
    assign_p2_snac      = 1,
    assign_p1p2_snac    = 2,
    assign_p1p2_swap    = 3,
    assign_all_snac     = 4,
    assign_all_reversed = 5,
    assign_p3p4_snac    = 6
  } assign_mode_t;

endpackage

/* hw/pad_router_top.sv */
//////////////////////////////
// pad router top level
// settings registers beside the
// three stage controller pipeline
//////////////////////////////

`timescale 1ns/1ps

module pad_router_top (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,

  // bridge
  input  pad_router_pkg::bridge_word_t  bridge_addr,
  input  logic                          bridge_wr,
  input  pad_router_pkg::bridge_word_t  bridge_wr_data,
  output pad_router_pkg::bridge_word_t  bridge_rd_data,

  // pocket controllers
  input  pad_router_pkg::pad_keys_t     cont1_key,
  input  pad_router_pkg::pad_keys_t     cont2_key,
  input  pad_router_pkg::pad_keys_t     cont3_key,
  input  pad_router_pkg::pad_keys_t     cont4_key,
  input  pad_router_pkg::bridge_word_t  cont1_joy,

  // adapter pad button words
  input  pad_router_pkg::pad_keys_t     snac1_btn,
  input  pad_router_pkg::pad_keys_t     snac2_btn,
  input  pad_router_pkg::pad_keys_t     snac3_btn,
  input  pad_router_pkg::pad_keys_t     snac4_btn,

  // player outputs
  output pad_router_pkg::pad_keys_t     p1_controls,
  output pad_router_pkg::pad_keys_t     p2_controls,
  output pad_router_pkg::pad_keys_t     p3_controls,
  output pad_router_pkg::pad_keys_t     p4_controls,
  output pad_router_pkg::stick_axis_t   p1_stick_x,
  output pad_router_pkg::stick_axis_t   p1_stick_y
);

  // settings
  pad_router_pkg::stick_axis_t  deadzone;
  pad_router_pkg::cont_type_t   cont_type;
  pad_router_pkg::assign_mode_t assign_mode;

  // stage 2 to stage 3
  pad_router_pkg::pad_keys_t    key1_q, key2_q, key3_q, key4_q;
  pad_router_pkg::pad_keys_t    snac1_q, snac2_q, snac3_q, snac4_q;
  pad_router_pkg::stick_axis_t  stick_x_q, stick_y_q;

  bridge_settings_regs settings_regs (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .deadzone       (deadzone),
    .cont_type      (cont_type),
    .assign_mode    (assign_mode)
  );

  stick_deadzone deadzone_stage (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cont1_key      (cont1_key),
    .cont2_key      (cont2_key),
    .cont3_key      (cont3_key),
    .cont4_key      (cont4_key),
    .cont1_joy      (cont1_joy),
    .snac1_btn      (snac1_btn),
    .snac2_btn      (snac2_btn),
    .snac3_btn      (snac3_btn),
    .snac4_btn      (snac4_btn),
    .deadzone       (deadzone),
    .key1_q         (key1_q),
    .key2_q         (key2_q),
    .key3_q         (key3_q),
    .key4_q         (key4_q),
    .snac1_q        (snac1_q),
    .snac2_q        (snac2_q),
    .snac3_q        (snac3_q),
    .snac4_q        (snac4_q),
    .stick_x_q      (stick_x_q),
    .stick_y_q      (stick_y_q)
  );

  player_select select_stage (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .key1           (key1_q),
    .key2           (key2_q),
    .key3           (key3_q),
    .key4           (key4_q),
    .snac1          (snac1_q),
    .snac2          (snac2_q),
    .snac3          (snac3_q),
    .snac4          (snac4_q),
    .stick_x        (stick_x_q),
    .stick_y        (stick_y_q),
    .cont_type      (cont_type),
    .assign_mode    (assign_mode),
    .p1_controls    (p1_controls),
    .p2_controls    (p2_controls),
    .p3_controls    (p3_controls),
    .p4_controls    (p4_controls),
    .p1_stick_x     (p1_stick_x),
    .p1_stick_y     (p1_stick_y)
  );

endmodule

/* hw/player_select.sv */
//////////////////////////////
// pipeline stage 3
// routes pocket and adapter pads to players
//////////////////////////////

`timescale 1ns/1ps

module player_select (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,

  // pocket controllers
  input  pad_router_pkg::pad_keys_t     key1,
  input  pad_router_pkg::pad_keys_t     key2,
  input  pad_router_pkg::pad_keys_t     key3,
  input  pad_router_pkg::pad_keys_t     key4,

  // adapter pads
  input  pad_router_pkg::pad_keys_t     snac1,
  input  pad_router_pkg::pad_keys_t     snac2,
  input  pad_router_pkg::pad_keys_t     snac3,
  input  pad_router_pkg::pad_keys_t     snac4,

  // calibrated player 1 stick
  input  pad_router_pkg::stick_axis_t   stick_x,
  input  pad_router_pkg::stick_axis_t   stick_y,

  input  pad_router_pkg::cont_type_t    cont_type,
  input  pad_router_pkg::assign_mode_t  assign_mode,

  output pad_router_pkg::pad_keys_t     p1_controls,
  output pad_router_pkg::pad_keys_t     p2_controls,
  output pad_router_pkg::pad_keys_t     p3_controls,
  output pad_router_pkg::pad_keys_t     p4_controls,
  output pad_router_pkg::stick_axis_t   p1_stick_x,
  output pad_router_pkg::stick_axis_t   p1_stick_y
);

  pad_router_pkg::pad_keys_t p1_next;
  pad_router_pkg::pad_keys_t p2_next;
  pad_router_pkg::pad_keys_t p3_next;
  pad_router_pkg::pad_keys_t p4_next;
  logic                      stick_on;

  //////////////////////////////
  // routing table
  //////////////////////////////

  always_comb begin
    // pocket pass-through unless a mode below overrides it
    p1_next  = key1;
    p2_next  = key2;
    p3_next  = key3;
    p4_next  = key4;
    stick_on = 1'b1;

    // adapter off when the type is zero
    if (cont_type != '0) begin
      case (assign_mode)
        pad_router_pkg::assign_p1_snac: begin
          p1_next  = snac1;
          stick_on = 1'b0;
        end
        pad_router_pkg::assign_p2_snac: begin
          p2_next = snac1;
        end
        pad_router_pkg::assign_p1p2_snac: begin
          p1_next  = snac1;
          p2_next  = snac2;
          stick_on = 1'b0;
        end
        pad_router_pkg::assign_p1p2_swap: begin
          p1_next  = snac2;
          p2_next  = snac1;
          stick_on = 1'b0;
        end
        pad_router_pkg::assign_all_snac: begin
          p1_next  = snac1;
          p2_next  = snac2;
          p3_next  = snac3;
          p4_next  = snac4;
          stick_on = 1'b0;
        end
        pad_router_pkg::assign_all_reversed: begin
          p1_next  = snac4;
          p2_next  = snac3;
          p3_next  = snac2;
          p4_next  = snac1;
          stick_on = 1'b0;
        end
        // player 1 stays on the pocket so the stick follows it
        pad_router_pkg::assign_p3p4_snac: begin
          p3_next = snac1;
          p4_next = snac2;
        end
        default: begin
        end
      endcase
    end
  end

  // stage 3 output registers
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      p1_controls <= '0;
      p2_controls <= '0;
      p3_controls <= '0;
      p4_controls <= '0;
      p1_stick_x  <= '0;
      p1_stick_y  <= '0;
    end else begin
      p1_controls <= p1_next;
      p2_controls <= p2_next;
      p3_controls <= p3_next;
      p4_controls <= p4_next;
      // adapter pad on player 1 has no stick
      p1_stick_x  <= stick_on ? stick_x : '0;
      p1_stick_y  <= stick_on ? stick_y : '0;
    end
  end

endmodule

/* hw/stick_deadzone.sv */
//////////////////////////////
// pipeline stages 1 and 2
// input capture and player 1 deadzone
//////////////////////////////

`timescale 1ns/1ps

`include "pad_router_settings.svh"

module stick_deadzone (
  input  logic                          clk_74a,
  input  logic                          pll_core_locked,

  input  pad_router_pkg::pad_keys_t     cont1_key,
  input  pad_router_pkg::pad_keys_t     cont2_key,
  input  pad_router_pkg::pad_keys_t     cont3_key,
  input  pad_router_pkg::pad_keys_t     cont4_key,
  input  pad_router_pkg::bridge_word_t  cont1_joy,
  input  pad_router_pkg::pad_keys_t     snac1_btn,
  input  pad_router_pkg::pad_keys_t     snac2_btn,
  input  pad_router_pkg::pad_keys_t     snac3_btn,
  input  pad_router_pkg::pad_keys_t     snac4_btn,
  input  pad_router_pkg::stick_axis_t   deadzone,

  output pad_router_pkg::pad_keys_t     key1_q,
  output pad_router_pkg::pad_keys_t     key2_q,
  output pad_router_pkg::pad_keys_t     key3_q,
  output pad_router_pkg::pad_keys_t     key4_q,
  output pad_router_pkg::pad_keys_t     snac1_q,
  output pad_router_pkg::pad_keys_t     snac2_q,
  output pad_router_pkg::pad_keys_t     snac3_q,
  output pad_router_pkg::pad_keys_t     snac4_q,
  output pad_router_pkg::stick_axis_t   stick_x_q,
  output pad_router_pkg::stick_axis_t   stick_y_q
);

  // distance of one axis from centre, 0 to 128
  function automatic logic [7:0] axis_deflection(input pad_router_pkg::stick_axis_t v);
    axis_deflection = v[7] ? {1'b0, v[6:0]} : `PR_STICK_CENTRE - {1'b0, v[6:0]};
  endfunction

  pad_router_pkg::pad_keys_t [3:0] key_s1;
  pad_router_pkg::pad_keys_t [3:0] snac_s1;
  pad_router_pkg::stick_axis_t     stick_x_s1;
  pad_router_pkg::stick_axis_t     stick_y_s1;

  logic [8:0] deflection_total;
  logic       stick_live;

  // stage 1, only the left stick of cont1 is kept
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      key_s1     <= '0;
      snac_s1    <= '0;
      stick_x_s1 <= '0;
      stick_y_s1 <= '0;
    end else begin
      key_s1     <= {cont4_key, cont3_key, cont2_key, cont1_key};
      snac_s1    <= {snac4_btn, snac3_btn, snac2_btn, snac1_btn};
      stick_x_s1 <= cont1_joy[7:0];
      stick_y_s1 <= cont1_joy[15:8];
    end
  end

  // deadzone is taken live here
  assign deflection_total = axis_deflection(stick_x_s1) + axis_deflection(stick_y_s1);
  assign stick_live       = deflection_total > {1'b0, deadzone};

  // stage 2, buttons just ride along with the stick
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      {key4_q, key3_q, key2_q, key1_q}     <= '0;
      {snac4_q, snac3_q, snac2_q, snac1_q} <= '0;
      stick_x_q <= '0;
      stick_y_q <= '0;
    end else begin
      {key4_q, key3_q, key2_q, key1_q}     <= key_s1;
      {snac4_q, snac3_q, snac2_q, snac1_q} <= snac_s1;
      stick_x_q <= stick_live ? stick_x_s1 : `PR_STICK_CENTRE;
      stick_y_q <= stick_live ? stick_y_s1 : `PR_STICK_CENTRE;
    end
  end

endmodule

/* include/pad_router_settings.svh */
//////////////////////////////
// bridge addresses, settings word field
// positions and the stick resting value
//////////////////////////////

`ifndef PAD_ROUTER_SETTINGS_SVH
`define PAD_ROUTER_SETTINGS_SVH

//////////////////////////////
// bridge addresses
//////////////////////////////

`define PR_ADDR_DEADZONE   32'h0000_010C
`define PR_ADDR_ANALOGIZER 32'hF700_0000

//////////////////////////////
// adapter settings word
//////////////////////////////

`define PR_SETTINGS_W    14

// controller type, zero when the adapter is off
`define PR_CONT_TYPE_LSB 0
`define PR_CONT_TYPE_W   5

// bit 5 is spare and bits 13:10 carry the video type
`define PR_ASSIGN_LSB    6
`define PR_ASSIGN_W      4

// unsigned axis at rest
`define PR_STICK_CENTRE  8'd128

`endif

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module pad_router_tb -o pad_router_sim

# the log decides the result, so a fatal exit must not stop the script here
./obj_dir/pad_router_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi

/* sources.f */
+incdir+include
hw/pad_router_pkg.sv
hw/bridge_settings_regs.sv
hw/stick_deadzone.sv
hw/player_select.sv
hw/pad_router_top.sv
verification/pad_router_chk.sv
verification/pad_router_tb.sv

/* verification/pad_router_chk.sv */
//////////////////////////////
// concurrent assertions on the pad router
// top level, attached with bind
//////////////////////////////

`timescale 1ns/1ps

`include "pad_router_settings.svh"

module pad_router_chk (
  input logic                        clk_74a,
  input logic                        pll_core_locked,
  input logic [31:0]                 bridge_addr,
  input logic [31:0]                 bridge_rd_data,
  input logic [15:0]                 p1_controls,
  input logic [15:0]                 p2_controls,
  input logic [15:0]                 p3_controls,
  input logic [15:0]                 p4_controls,
  input logic [7:0]                  p1_stick_x,
  input logic [7:0]                  p1_stick_y,
  input logic [`PR_CONT_TYPE_W-1:0]  cont_type,
  input logic [`PR_ASSIGN_W-1:0]     assign_mode
);

  // only the adapter word is readable
  unmapped_read_zero: assert property (@(posedge clk_74a)
    (bridge_addr != `PR_ADDR_ANALOGIZER) |-> (bridge_rd_data == '0))
    else $error("bridge read of an unmapped address returned non-zero data");

  outputs_known: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !$isunknown({p1_controls, p2_controls, p3_controls, p4_controls, p1_stick_x, p1_stick_y}))
    else $error("player outputs carry unknown bits");

  // adapter pad on player 1 means no stick, modes 0 and 2 to 5
  stick_off_for_pad: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (cont_type != '0 && assign_mode <= 4'd5 && assign_mode != 4'd1)
    |=> (p1_stick_x == '0 && p1_stick_y == '0))
    else $error("player 1 stick is not zero while an adapter pad holds player 1");

endmodule

bind pad_router_top pad_router_chk chk (.*);

/* verification/pad_router_tb.sv */
//////////////////////////////
// pad router testbench
// reference model, directed tests,
// value check and cycle limit
//////////////////////////////

`timescale 1ns/1ps

`include "pad_router_settings.svh"

module pad_router_tb;

  // about 350 cycles of tests, limit leaves a wide margin
  localparam int CYCLE_LIMIT = 2000;

  logic        clk_74a;
  logic        pll_core_locked;
  logic [31:0] bridge_addr;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic [31:0] bridge_rd_data;
  // 0 to 3 pocket keys, 4 to 7 adapter buttons
  logic [15:0] pad_in [0:7];
  logic [31:0] joy_in;
  logic [15:0] p1_controls, p2_controls, p3_controls, p4_controls;
  logic [7:0]  p1_stick_x, p1_stick_y;

  // settings as the testbench believes them to be
  logic [13:0] shadow_cfg;
  logic [7:0]  shadow_dz;
  integer      seed;
  int          cycle_count;
  int          error_count;
  string       test_name;

  pad_router_top dut (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd_data (bridge_rd_data),
    .cont1_key      (pad_in[0]),
    .cont2_key      (pad_in[1]),
    .cont3_key      (pad_in[2]),
    .cont4_key      (pad_in[3]),
    .cont1_joy      (joy_in),
    .snac1_btn      (pad_in[4]),
    .snac2_btn      (pad_in[5]),
    .snac3_btn      (pad_in[6]),
    .snac4_btn      (pad_in[7]),
    .p1_controls    (p1_controls),
    .p2_controls    (p2_controls),
    .p3_controls    (p3_controls),
    .p4_controls    (p4_controls),
    .p1_stick_x     (p1_stick_x),
    .p1_stick_y     (p1_stick_y)
  );

  initial begin
    clk_74a = 1'b0;
    forever #4 clk_74a = ~clk_74a;
  end

  always @(posedge clk_74a) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Testbench failed");
      $fatal(1, "cycle limit reached");
    end
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // nibble n names the source of player n+1, 0-3 pocket and 4-7 adapter
  function automatic logic [15:0] route_row(input logic [3:0] mode);
    case (mode)
      4'd0:    route_row = 16'h3214;
      4'd1:    route_row = 16'h3240;
      4'd2:    route_row = 16'h3254;
      4'd3:    route_row = 16'h3245;
      4'd4:    route_row = 16'h7654;
      4'd5:    route_row = 16'h4567;
      4'd6:    route_row = 16'h5410;
      default: route_row = 16'h3210;
    endcase
  endfunction

  function automatic logic [15:0] calibrated_stick(input logic [15:0] joy, input logic [7:0] dz);
    logic [9:0] dx;
    logic [9:0] dy;
    dx = (joy[7:0] >= 8'd128) ? {2'b0, joy[7:0]} - 10'd128 : 10'd128 - {2'b0, joy[7:0]};
    dy = (joy[15:8] >= 8'd128) ? {2'b0, joy[15:8]} - 10'd128 : 10'd128 - {2'b0, joy[15:8]};
    calibrated_stick = (dx + dy > {2'b0, dz}) ? joy : {`PR_STICK_CENTRE, `PR_STICK_CENTRE};
  endfunction

  task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("ERROR %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  //////////////////////////////
  // bridge and stimulus helpers
  //////////////////////////////

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(posedge clk_74a);
    #1;
    bridge_wr = 1'b0;
    if (addr == `PR_ADDR_ANALOGIZER) shadow_cfg = data[`PR_SETTINGS_W-1:0];
    else if (addr == `PR_ADDR_DEADZONE) shadow_dz = data[7:0];
  endtask

  // readback sampled mid cycle
  task automatic bridge_read_check(input logic [31:0] addr, input logic [31:0] expected);
    bridge_addr = addr;
    @(negedge clk_74a);
    check("bridge_rd_data", expected, bridge_rd_data);
    @(posedge clk_74a);
    #1;
  endtask

  task automatic randomize_pads;
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      pad_in[i] = r[15:0];
    end
  endtask

  task automatic write_cfg(input logic [4:0] ct, input logic [3:0] mode);
    logic [31:0] r;
    r = $random(seed);
    r[`PR_CONT_TYPE_LSB +: `PR_CONT_TYPE_W] = ct;
    r[`PR_ASSIGN_LSB +: `PR_ASSIGN_W] = mode;
    bridge_write(`PR_ADDR_ANALOGIZER, r);
  endtask

  // inputs are already applied, result is due 3 edges later
  task automatic run_sample;
    logic [15:0] row;
    logic [15:0] exp_pad [0:3];
    logic [15:0] stick;
    if (shadow_cfg[`PR_CONT_TYPE_LSB +: `PR_CONT_TYPE_W] != '0)
      row = route_row(shadow_cfg[`PR_ASSIGN_LSB +: `PR_ASSIGN_W]);
    else
      row = 16'h3210;
    for (int p = 0; p < 4; p++) exp_pad[p] = pad_in[row[p*4 +: 3]];
    stick = (row[3:0] == 4'd0) ? calibrated_stick(joy_in[15:0], shadow_dz) : 16'h0000;
    @(posedge clk_74a);
    #1;
    // the following sample differs in every bit
    for (int i = 0; i < 8; i++) pad_in[i] = ~pad_in[i];
    joy_in = ~joy_in;
    repeat (2) @(posedge clk_74a);
    #1;
    check("p1_controls", 32'(exp_pad[0]), 32'(p1_controls));
    check("p2_controls", 32'(exp_pad[1]), 32'(p2_controls));
    check("p3_controls", 32'(exp_pad[2]), 32'(p3_controls));
    check("p4_controls", 32'(exp_pad[3]), 32'(p4_controls));
    check("p1_stick_x", 32'(stick[7:0]), 32'(p1_stick_x));
    check("p1_stick_y", 32'(stick[15:8]), 32'(p1_stick_y));
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic reset_state_test;
    test_name = "reset_state";
    check("p1_controls", 32'd0, 32'(p1_controls));
    check("p2_controls", 32'd0, 32'(p2_controls));
    check("p3_controls", 32'd0, 32'(p3_controls));
    check("p4_controls", 32'd0, 32'(p4_controls));
    check("p1_stick_x", 32'd0, 32'(p1_stick_x));
    check("p1_stick_y", 32'd0, 32'(p1_stick_y));
    bridge_read_check(`PR_ADDR_ANALOGIZER, 32'd0);
  endtask

  task automatic settings_test;
    logic [31:0] r;
    test_name = "settings";
    for (int i = 0; i < 4; i++) begin
      r = $random(seed);
      bridge_write(`PR_ADDR_ANALOGIZER, r);
      bridge_read_check(`PR_ADDR_ANALOGIZER, r & 32'h0000_3FFF);
      // unmapped writes leave the word alone
      bridge_write(`PR_ADDR_ANALOGIZER + 32'h4, ~r);
      bridge_write(32'h0000_0000, ~r);
      bridge_read_check(`PR_ADDR_ANALOGIZER, r & 32'h0000_3FFF);
      // deadzone holds a non-zero value but is write only
      bridge_write(`PR_ADDR_DEADZONE, r | 32'h0000_0001);
      bridge_read_check(`PR_ADDR_DEADZONE, 32'd0);
      bridge_read_check(`PR_ADDR_ANALOGIZER ^ 32'h1, 32'd0);
    end
  endtask

  task automatic deadzone_test;
    logic [7:0]  dz_list [0:2] = '{8'd0, 8'd40, 8'd200};
    // centre, both extremes, totals of 40 and 41 on each axis, near centre
    logic [15:0] edges [0:7] = '{16'h8080, 16'h0000, 16'hFFFF, 16'h80A8,
                                 16'h80A9, 16'h5880, 16'h5780, 16'h7F81};
    logic [31:0] r;
    test_name = "deadzone";
    write_cfg(5'd0, 4'd0);
    for (int d = 0; d < 3; d++) begin
      bridge_write(`PR_ADDR_DEADZONE, {24'hABCDEF, dz_list[d]});
      for (int k = 0; k < 12; k++) begin
        randomize_pads();
        r = $random(seed);
        joy_in = (k < 8) ? {r[31:16], edges[k]} : r;
        run_sample();
      end
    end
  endtask

  task automatic passthrough_test;
    test_name = "passthrough";
    for (int m = 0; m < 16; m++) begin
      write_cfg(5'd0, 4'(m));
      randomize_pads();
      joy_in = $random(seed);
      run_sample();
    end
  endtask

  task automatic assign_test;
    logic [4:0] ct_list [0:2] = '{5'd1, 5'd16, 5'd31};
    test_name = "assign_modes";
    bridge_write(`PR_ADDR_DEADZONE, 32'd10);
    for (int c = 0; c < 3; c++) begin
      // modes 0 to 7, then 12 as a second default code
      for (int m = 0; m < 9; m++) begin
        write_cfg(ct_list[c], (m == 8) ? 4'd12 : 4'(m));
        randomize_pads();
        joy_in = $random(seed);
        run_sample();
      end
    end
  endtask

  initial begin
    seed            = 57;
    cycle_count     = 0;
    error_count     = 0;
    test_name       = "init";
    pll_core_locked = 1'b0;
    // live inputs and a settings write while reset is held
    bridge_addr     = `PR_ADDR_ANALOGIZER;
    bridge_wr       = 1'b1;
    bridge_wr_data  = '1;
    joy_in          = 32'h0000_10F0;
    shadow_cfg      = '0;
    shadow_dz       = '0;
    for (int i = 0; i < 8; i++) pad_in[i] = 16'hA5A5 ^ 16'(i);

    repeat (3) @(posedge clk_74a);
    #1;
    pll_core_locked = 1'b1;
    bridge_wr       = 1'b0;

    reset_state_test();
    settings_test();
    deadzone_test();
    passthrough_test();
    assign_test();

    if (error_count == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1, "checks failed");
    end
  end

endmodule
